// File: logic/fir_pkg.sv
package fir_pkg;

	localparam int num_taps = 24;
	localparam int tap_index_bits = 5;    // Coefficient address width
	localparam int sample_bits = 16;
	localparam int coef_bits = 16;        // Signed Q1.15
	localparam int frac_bits = 15;
	localparam int product_bits = sample_bits + coef_bits;
	localparam int acc_bits = 37;         // Product plus growth for 24 terms
	localparam int mac_latency = 6;       // Product stage plus five tree stages

	typedef logic signed [sample_bits-1:0] sample_t;
	typedef logic signed [coef_bits-1:0] coef_t;
	typedef logic signed [product_bits-1:0] product_t;
	typedef logic signed [acc_bits-1:0] acc_t;

	// Clamp limits of the output
	localparam sample_t sample_max = sample_t'(2 ** (sample_bits - 1) - 1);
	localparam sample_t sample_min = sample_t'(-(2 ** (sample_bits - 1)));

	typedef struct packed {
		logic [tap_index_bits-1:0] address;
		coef_t data;
	} coef_write_t;

	typedef struct packed {
		sample_t value;
		logic saturated;    // Set when the value was clamped
	} fir_result_t;

endpackage

// File: logic/tap_delay_line.sv
`timescale 1ns/1ps

module tap_delay_line (
	input logic clk,
	input logic reset,
	input logic shift,
	input fir_pkg::sample_t sample_in,
	output fir_pkg::sample_t taps [fir_pkg::num_taps]
);

	// Tap 0 holds the newest sample, the last tap the oldest
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < fir_pkg::num_taps; i++) begin
				taps[i] <= '0;
			end
		end else if (shift) begin
			taps[0] <= sample_in;
			for (int i = 1; i < fir_pkg::num_taps; i++) begin
				taps[i] <= taps[i-1];    // Age by one position
			end
		end
	end

	// An unknown sample would spread into every later output for num_taps samples
	sample_known: assert property (
		@(posedge clk) disable iff (reset)
		shift |-> !$isunknown(sample_in)
	) else $error("tap_delay_line: sample_in has unknown bits on shift");

endmodule

// File: logic/coef_bank.sv
`timescale 1ns/1ps

module coef_bank (
	input logic clk,
	input logic reset,
	input logic coef_we,
	input fir_pkg::coef_write_t coef_wr,
	output fir_pkg::coef_t coefs [fir_pkg::num_taps]
);

	logic address_ok;

	assign address_ok = coef_wr.address < fir_pkg::num_taps;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < fir_pkg::num_taps; i++) begin
				coefs[i] <= '0;
			end
		end else if (coef_we && address_ok) begin
			coefs[coef_wr.address] <= coef_wr.data;    // Seen by the tree next cycle
		end
	end

	// Out-of-range writes are dropped by the register file
	write_in_range: assert property (
		@(posedge clk) disable iff (reset)
		coef_we |-> address_ok
	) else $error("coef_bank: write to address %0d beyond the last tap", coef_wr.address);

endmodule

// File: logic/mac_tree.sv
`timescale 1ns/1ps

module mac_tree (
	input logic clk,
	input logic reset,
	input logic in_valid,
	input fir_pkg::sample_t taps [fir_pkg::num_taps],
	input fir_pkg::coef_t coefs [fir_pkg::num_taps],
	output fir_pkg::acc_t acc,
	output logic acc_valid
);

	localparam int n_12 = fir_pkg::num_taps / 2;
	localparam int n_6 = n_12 / 2;

	fir_pkg::product_t products [fir_pkg::num_taps];
	fir_pkg::acc_t sum_12 [n_12];
	fir_pkg::acc_t sum_6 [n_6];
	fir_pkg::acc_t sum_3 [3];
	fir_pkg::acc_t sum_2 [2];
	logic [fir_pkg::mac_latency-1:0] valid_sr;

	// Stage 1 forms one product per tap
	always_ff @(posedge clk) begin
		for (int i = 0; i < fir_pkg::num_taps; i++) begin
			products[i] <= taps[i] * coefs[i];
		end
	end

	// Stage 2 adds pairs of products widened to the accumulator
	always_ff @(posedge clk) begin
		for (int i = 0; i < n_12; i++) begin
			sum_12[i] <= fir_pkg::acc_t'(products[2*i]) + fir_pkg::acc_t'(products[2*i+1]);
		end
	end

	// Stage 3
	always_ff @(posedge clk) begin
		for (int i = 0; i < n_6; i++) begin
			sum_6[i] <= sum_12[2*i] + sum_12[2*i+1];
		end
	end

	// Stage 4
	always_ff @(posedge clk) begin
		for (int i = 0; i < 3; i++) begin
			sum_3[i] <= sum_6[2*i] + sum_6[2*i+1];
		end
	end

	// Stage 5 passes the odd last term along
	always_ff @(posedge clk) begin
		sum_2[0] <= sum_3[0] + sum_3[1];
		sum_2[1] <= sum_3[2];
	end

	// Stage 6
	always_ff @(posedge clk) begin
		acc <= sum_2[0] + sum_2[1];
	end

	// One valid bit per pipeline stage
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			valid_sr <= '0;
		end else begin
			valid_sr <= {valid_sr[fir_pkg::mac_latency-2:0], in_valid};
		end
	end

	assign acc_valid = valid_sr[fir_pkg::mac_latency-1];

	valid_after_latency: assert property (
		@(posedge clk) disable iff (reset)
		in_valid |-> ##(fir_pkg::mac_latency) acc_valid
	) else $error("mac_tree: acc_valid missing %0d cycles after in_valid",
		fir_pkg::mac_latency);

endmodule

// File: logic/output_scaler.sv
`timescale 1ns/1ps

module output_scaler (
	input logic clk,
	input logic reset,
	input fir_pkg::acc_t acc,
	input logic acc_valid,
	output fir_pkg::fir_result_t result,
	output logic result_valid
);

	fir_pkg::acc_t rounded;
	fir_pkg::acc_t shifted;
	logic too_high;
	logic too_low;

	// Round half up, then drop the coefficient fraction
	assign rounded = acc + (fir_pkg::acc_t'(1) <<< (fir_pkg::frac_bits - 1));
	assign shifted = rounded >>> fir_pkg::frac_bits;

	assign too_high = shifted > fir_pkg::acc_t'(fir_pkg::sample_max);
	assign too_low = shifted < fir_pkg::acc_t'(fir_pkg::sample_min);

	always_ff @(posedge clk) begin
		if (too_high) begin
			result.value <= fir_pkg::sample_max;
		end else if (too_low) begin
			result.value <= fir_pkg::sample_min;
		end else begin
			result.value <= fir_pkg::sample_t'(shifted);    // Already in range
		end
		result.saturated <= too_high || too_low;
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			result_valid <= 1'b0;
		end else begin
			result_valid <= acc_valid;
		end
	end

	// A flagged result must sit on one of the rails
	saturated_on_rail: assert property (
		@(posedge clk) disable iff (reset)
		result_valid && result.saturated |->
			result.value == fir_pkg::sample_max || result.value == fir_pkg::sample_min
	) else $error("output_scaler: saturated set with value %h", result.value);

endmodule

// File: logic/fir_filter.sv
`timescale 1ns/1ps

module fir_filter (
	input logic clk,
	input logic reset,
	input fir_pkg::sample_t sample_in,
	input logic sample_valid,
	input logic coef_we,
	input fir_pkg::coef_write_t coef_wr,
	output fir_pkg::fir_result_t result,
	output logic result_valid
);

	fir_pkg::sample_t taps [fir_pkg::num_taps];
	fir_pkg::coef_t coefs [fir_pkg::num_taps];
	fir_pkg::acc_t acc;
	logic acc_valid;
	logic mac_valid;

	// Taps shift on the strobe edge, so the tree sees them one cycle later
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			mac_valid <= 1'b0;
		end else begin
			mac_valid <= sample_valid;
		end
	end

	tap_delay_line tap_delay_line_i (
		.clk(clk),
		.reset(reset),
		.shift(sample_valid),
		.sample_in(sample_in),
		.taps(taps)
	);

	coef_bank coef_bank_i (
		.clk(clk),
		.reset(reset),
		.coef_we(coef_we),
		.coef_wr(coef_wr),
		.coefs(coefs)
	);

	mac_tree mac_tree_i (
		.clk(clk),
		.reset(reset),
		.in_valid(mac_valid),
		.taps(taps),
		.coefs(coefs),
		.acc(acc),
		.acc_valid(acc_valid)
	);

	output_scaler output_scaler_i (
		.clk(clk),
		.reset(reset),
		.acc(acc),
		.acc_valid(acc_valid),
		.result(result),
		.result_valid(result_valid)
	);

endmodule

// File: verification/fir_filter_tb.sv
`timescale 1ns/1ps

module fir_filter_tb;

	localparam int latency = 7;    // Sample strobe edge to result_valid
	localparam int total_samples = 346;
	localparam int watchdog_cycles = total_samples * 10 + 200;
	localparam longint out_max = (longint'(1) <<< (fir_pkg::sample_bits - 1)) - 1;
	localparam longint out_min = -(longint'(1) <<< (fir_pkg::sample_bits - 1));

	logic clk;
	logic reset;
	fir_pkg::sample_t sample_in;
	logic sample_valid;
	logic coef_we;
	fir_pkg::coef_write_t coef_wr;
	fir_pkg::fir_result_t result;
	logic result_valid;

	int cycle;
	logic [31:0] rng_state;
	int model_taps [fir_pkg::num_taps];    // Tap 0 newest
	int model_coefs [fir_pkg::num_taps];
	fir_pkg::fir_result_t expected_q [$];
	int strobe_q [$];    // Edge at which each sample was taken
	int value_errors;
	int latency_errors;
	int protocol_errors;
	int sat_high_seen;
	int sat_low_seen;

	fir_filter fir_filter_i (
		.clk(clk),
		.reset(reset),
		.sample_in(sample_in),
		.sample_valid(sample_valid),
		.coef_we(coef_we),
		.coef_wr(coef_wr),
		.result(result),
		.result_valid(result_valid)
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	function automatic logic [31:0] next_random();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state;
	endfunction

	function automatic fir_pkg::sample_t random_sample();
		return fir_pkg::sample_t'(next_random());
	endfunction

	// Kept to an eighth of full scale so most sums stay in range
	function automatic fir_pkg::coef_t random_coef();
		fir_pkg::coef_t c;
		c = fir_pkg::coef_t'(next_random());
		return c >>> 3;
	endfunction

	function automatic void model_shift(int s);
		for (int i = fir_pkg::num_taps - 1; i > 0; i--) begin
			model_taps[i] = model_taps[i-1];
		end
		model_taps[0] = s;
	endfunction

	// Exact dot product, round half up, arithmetic shift, clamp
	function automatic fir_pkg::fir_result_t model_output();
		longint sum;
		longint scaled;
		fir_pkg::fir_result_t r;
		sum = 0;
		for (int i = 0; i < fir_pkg::num_taps; i++) begin
			sum += longint'(model_taps[i]) * longint'(model_coefs[i]);
		end
		scaled = (sum + (longint'(1) <<< (fir_pkg::frac_bits - 1))) >>> fir_pkg::frac_bits;
		r.saturated = 1'b0;
		if (scaled > out_max) begin
			scaled = out_max;
			r.saturated = 1'b1;
		end else if (scaled < out_min) begin
			scaled = out_min;
			r.saturated = 1'b1;
		end
		r.value = fir_pkg::sample_t'(scaled);
		return r;
	endfunction

	task automatic check_result(fir_pkg::fir_result_t expected, fir_pkg::fir_result_t actual);
		if (actual !== expected) begin
			$display("Mismatch result: expected value %h saturated %h, actual value %h saturated %h",
				expected.value, expected.saturated, actual.value, actual.saturated);
			value_errors++;
		end
	endtask

	task automatic check_latency(int expected, int actual);
		if (actual != expected) begin
			$display("Mismatch result_valid latency: expected %h, actual %h", expected, actual);
			latency_errors++;
		end
	endtask

	// Results are read mid-cycle while they are stable
	always @(negedge clk) begin : monitor
		fir_pkg::fir_result_t expected;
		int strobe;
		if (!reset && result_valid) begin
			if (expected_q.size() == 0) begin
				$display("Extra result pulse at cycle %0d with no sample in flight", cycle);
				protocol_errors++;
			end else begin
				expected = expected_q.pop_front();
				strobe = strobe_q.pop_front();
				check_result(expected, result);
				check_latency(latency, cycle - strobe);
				if (result.saturated) begin
					if (result.value < 0) begin
						sat_low_seen++;
					end else begin
						sat_high_seen++;
					end
				end
			end
		end
	end

	task automatic idle(int n);
		repeat (n) begin
			@(posedge clk);
			#0.5;
			sample_valid = 1'b0;
			coef_we = 1'b0;
			sample_in = '0;
		end
	endtask

	task automatic send_sample(fir_pkg::sample_t s);
		@(posedge clk);
		#0.5;
		sample_in = s;
		sample_valid = 1'b1;
		coef_we = 1'b0;
		model_shift(int'(s));
		expected_q.push_back(model_output());
		strobe_q.push_back(cycle + 1);    // Taken at the coming edge
	endtask

	task automatic write_coef(int address, fir_pkg::coef_t data);
		@(posedge clk);
		#0.5;
		sample_valid = 1'b0;
		coef_we = 1'b1;
		coef_wr.address = address[fir_pkg::tap_index_bits-1:0];
		coef_wr.data = data;
		model_coefs[address] = int'(data);
	endtask

	task automatic load_random_coefs();
		for (int i = 0; i < fir_pkg::num_taps; i++) begin
			write_coef(i, random_coef());
		end
		idle(1);
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		idle(1);
		while (expected_q.size() != 0 && waited < 4 * latency) begin
			@(posedge clk);
			waited++;
		end
		if (expected_q.size() != 0) begin
			$display("%0d results never arrived", expected_q.size());
			protocol_errors++;
			expected_q.delete();
			strobe_q.delete();
		end
	endtask

	task automatic apply_reset();
		@(posedge clk);
		#0.5;
		reset = 1'b1;
		sample_valid = 1'b0;
		coef_we = 1'b0;
		sample_in = '0;
		coef_wr = '0;
		repeat (4) @(posedge clk);
		#0.5;
		reset = 1'b0;
		for (int i = 0; i < fir_pkg::num_taps; i++) begin
			model_taps[i] = 0;
			model_coefs[i] = 0;
		end
	endtask

	task automatic reset_state_zero();
		apply_reset();
		repeat (20) begin
			@(negedge clk);
			if (result_valid !== 1'b0) begin
				$display("result_valid is not low while no sample has arrived after reset");
				protocol_errors++;
			end
		end
		repeat (12) send_sample(random_sample());    // Zero coefficients give zero
		wait_drain();
	endtask

	task automatic impulse_response();
		apply_reset();
		for (int i = 0; i < fir_pkg::num_taps; i++) begin
			write_coef(i, fir_pkg::coef_t'((i - 12) * 2500 + 37));
		end
		idle(1);
		send_sample(fir_pkg::sample_t'(32767));
		repeat (fir_pkg::num_taps - 1) send_sample('0);
		wait_drain();
	endtask

	task automatic back_to_back_stream();
		load_random_coefs();
		repeat (100) send_sample(random_sample());
		wait_drain();
	endtask

	task automatic gapped_stream();
		for (int i = 0; i < 60; i++) begin
			send_sample(random_sample());
			idle(int'(next_random() % 4));
		end
		wait_drain();
	endtask

	task automatic saturate_both_rails();
		int high_before;
		int low_before;
		high_before = sat_high_seen;
		low_before = sat_low_seen;
		for (int i = 0; i < fir_pkg::num_taps; i++) begin
			write_coef(i, fir_pkg::coef_t'(32767));
		end
		idle(1);
		repeat (30) send_sample(fir_pkg::sample_t'(32767));
		repeat (30) send_sample(fir_pkg::sample_t'(-32768));
		// Last few of these see only small history, so no flag
		repeat (30) send_sample(fir_pkg::sample_t'(int'(next_random() % 17) - 8));
		wait_drain();
		if (sat_high_seen == high_before) begin
			$display("No positive saturated result seen in the saturation test");
			protocol_errors++;
		end
		if (sat_low_seen == low_before) begin
			$display("No negative saturated result seen in the saturation test");
			protocol_errors++;
		end
	endtask

	task automatic coef_reload();
		load_random_coefs();
		repeat (20) send_sample(random_sample());
		wait_drain();
		for (int i = 0; i < fir_pkg::num_taps; i += 2) begin
			write_coef(i, random_coef());
		end
		idle(1);
		repeat (40) send_sample(random_sample());
		wait_drain();
	endtask

	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("Watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
		$display("Verification failed");
		$finish;
	end

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		sample_in = '0;
		sample_valid = 1'b0;
		coef_we = 1'b0;
		coef_wr = '0;
		cycle = 0;
		rng_state = 32'd9;
		value_errors = 0;
		latency_errors = 0;
		protocol_errors = 0;
		sat_high_seen = 0;
		sat_low_seen = 0;
		reset_state_zero();
		impulse_response();
		back_to_back_stream();
		gapped_stream();
		saturate_both_rails();
		coef_reload();
		$display("Errors: value %0d, latency %0d, protocol %0d",
			value_errors, latency_errors, protocol_errors);
		if (value_errors + latency_errors + protocol_errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// File: list.f
logic/fir_pkg.sv
logic/tap_delay_line.sv
logic/coef_bank.sv
logic/mac_tree.sv
logic/output_scaler.sv
logic/fir_filter.sv
verification/fir_filter_tb.sv
